// ==== hw/enigma_pkg.sv ====
package enigma_pkg;

    // ==============================
    // Widths with a meaning
    // ==============================
    typedef logic [4:0]  letter_idx_t;
    typedef logic [2:0]  rotor_sel_t;
    typedef logic [7:0]  byte_t;
    typedef logic [14:0] cfg_data_t;

    // ==============================
    // Limits and characters
    // ==============================
    localparam int LETTER_COUNT = 26;
    localparam int ROTOR_COUNT  = 5;

    localparam int unsigned STARTUP_DELAY_DEFAULT = 12000;
    // Roughly 256 byte times at 115200 baud
    localparam int unsigned TIMEOUT_DEFAULT = 266240;

    localparam byte_t CHAR_CR    = 8'h0D;
    localparam byte_t CHAR_LF    = 8'h0A;
    localparam byte_t CHAR_COLON = 8'h3A;
    localparam byte_t CHAR_A     = 8'h41;

    // "ENIGMA I READY" plus CR LF
    localparam int BANNER_LEN = 16;

    // ==============================
    // Transfer types
    // ==============================
    typedef enum logic [1:0] {
        ROTOR,
        RING,
        GROUND
    } cfg_kind_e;

    typedef struct packed {
        logic      valid;
        cfg_kind_e kind;
        cfg_data_t data;
    } cfg_write_t;

    typedef struct packed {
        logic  valid;
        byte_t ch;
    } letter_req_t;

    typedef struct packed {
        logic valid;
        logic ok;
    } reply_req_t;

    typedef struct packed {
        logic  valid;
        byte_t data;
    } rx_t;

    // Clearing bit 5 folds lower case onto upper case
    function automatic byte_t upper_case(input byte_t c);
        return c & 8'hDF;
    endfunction

    function automatic logic is_letter(input byte_t c);
        return (upper_case(c) >= CHAR_A) && (upper_case(c) < CHAR_A + LETTER_COUNT);
    endfunction

    function automatic letter_idx_t letter_of(input byte_t c);
        return letter_idx_t'(upper_case(c) - CHAR_A);
    endfunction

endpackage

// ==== hw/keystroke_sequencer.sv ====
`timescale 1ns/100ps

module keystroke_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  enigma_pkg::rx_t         rx,
    input  logic                    input_open,
    input  logic                    cmd_active,
    input  enigma_pkg::letter_idx_t ct_index,
    output enigma_pkg::letter_idx_t pt_index,
    output logic                    step_pulse,
    output enigma_pkg::letter_req_t letter_req,
    input  logic                    letter_ready,
    output logic                    letter_busy
);

    import enigma_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_STEP,
        S_SETTLE,
        S_SAMPLE,
        S_REQUEST
    } seq_state_e;

    seq_state_e state;
    byte_t      ct_char;
    logic       accept;

    // Letters only while no command is open
    assign accept = (state == S_IDLE) && rx.valid && input_open && !cmd_active
                    && is_letter(rx.data);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_STEP;
                    end
                end
                S_STEP:   state <= S_SETTLE;
                S_SETTLE: state <= S_SAMPLE;
                S_SAMPLE: state <= S_REQUEST;
                S_REQUEST: begin
                    if (letter_ready) begin
                        state <= S_IDLE;
                    end
                end
                default:  state <= S_IDLE;
            endcase
        end
    end

    // Plaintext index and ciphertext character
    always_ff @(posedge clk) begin
        if (accept) begin
            pt_index <= letter_of(rx.data);
        end
        if (state == S_SAMPLE) begin
            ct_char <= CHAR_A + byte_t'(ct_index);
        end
    end

    // Stepper sees exactly one cycle of S_STEP
    assign step_pulse  = (state == S_STEP);
    assign letter_busy = (state != S_IDLE);
    assign letter_req  = '{valid: (state == S_REQUEST), ch: ct_char};

endmodule

// ==== hw/command_parser.sv ====
`timescale 1ns/100ps

module command_parser #(
    parameter int unsigned timeout_cycles = enigma_pkg::TIMEOUT_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  enigma_pkg::rx_t        rx,
    input  logic                   input_open,
    input  logic                   letter_busy,
    output logic                   cmd_active,
    output enigma_pkg::cfg_write_t cfg_wr,
    output logic                   load_pulse,
    output enigma_pkg::reply_req_t reply_req,
    input  logic                   reply_ready,
    output logic                   error_led
);

    import enigma_pkg::*;

    typedef enum logic [2:0] {
        P_IDLE,
        P_OPCODE,
        P_ARGS,
        P_EXEC,
        P_REPLY
    } parse_state_e;

    typedef logic [$clog2(timeout_cycles + 1) - 1:0] tmo_cnt_t;

    parse_state_e state;
    tmo_cnt_t     idle_cnt;
    cfg_kind_e    cmd_kind;
    cfg_kind_e    new_kind;
    cfg_data_t    arg_buf;
    logic [1:0]   arg_cnt;
    logic         args_ok;
    logic         reply_ok;
    logic         wr_pending;
    logic         load_pending;

    byte_t        rx_upper;
    logic         is_colon;
    logic         is_eol;
    logic         is_arg_opcode;
    logic         digit_ok;
    rotor_sel_t   digit;
    logic         arg_ok;
    logic         arg_take;
    rotor_sel_t   rotor_first;
    rotor_sel_t   rotor_second;
    rotor_sel_t   rotor_third;
    logic         rotors_distinct;
    logic         colon_accept;
    logic         letter_accept;
    logic         timed_out;
    logic         finish;
    logic         pass;

    // ==============================
    // Byte classification
    // ==============================
    assign rx_upper      = upper_case(rx.data);
    assign is_colon      = (rx.data == CHAR_COLON);
    assign is_eol        = (rx.data == CHAR_CR) || (rx.data == CHAR_LF);
    assign is_arg_opcode = (rx_upper == "R") || (rx_upper == "N") || (rx_upper == "P");

    // Rotor digits 1 to 5 map onto 0 to 4
    assign digit_ok = (rx.data >= byte_t'("1")) && (rx.data < byte_t'("1") + ROTOR_COUNT);
    assign digit    = rotor_sel_t'(rx.data - byte_t'("1"));
    assign arg_ok   = (cmd_kind == ROTOR) ? digit_ok : is_letter(rx.data);

    always_comb begin
        case (rx_upper)
            "R":     new_kind = ROTOR;
            "N":     new_kind = RING;
            default: new_kind = GROUND;
        endcase
    end

    assign rotor_first     = arg_buf[8:6];
    assign rotor_second    = arg_buf[5:3];
    assign rotor_third     = arg_buf[2:0];
    assign rotors_distinct = (rotor_first != rotor_second) && (rotor_first != rotor_third)
                             && (rotor_second != rotor_third);

    assign colon_accept  = (state == P_IDLE) && rx.valid && is_colon && input_open
                           && !letter_busy;
    // Same rule the keystroke path uses to take a letter
    assign letter_accept = (state == P_IDLE) && rx.valid && is_letter(rx.data) && input_open
                           && !letter_busy;
    assign timed_out     = (idle_cnt == tmo_cnt_t'(timeout_cycles));
    assign arg_take      = (state == P_ARGS) && rx.valid && !is_colon && !is_eol
                           && (arg_cnt != 2'd3);

    // ==============================
    // Verdict
    // ==============================
    always_comb begin
        finish = 1'b0;
        pass   = 1'b0;
        if (rx.valid && (state == P_OPCODE) && !is_colon && !is_arg_opcode) begin
            finish = 1'b1;
            pass   = (rx_upper == "G");
        end
        if (rx.valid && (state == P_ARGS) && is_eol) begin
            finish = 1'b1;
            pass   = (arg_cnt == 2'd3) && args_ok && ((cmd_kind != ROTOR) || rotors_distinct);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= P_IDLE;
            error_led    <= 1'b0;
            reply_ok     <= 1'b0;
            wr_pending   <= 1'b0;
            load_pending <= 1'b0;
        end else begin
            case (state)
                P_IDLE: begin
                    if (colon_accept) begin
                        state     <= P_OPCODE;
                        error_led <= 1'b0;
                    end else if (letter_accept) begin
                        error_led <= 1'b0;
                    end
                end
                P_OPCODE: begin
                    if (rx.valid && !is_colon && is_arg_opcode) begin
                        state <= P_ARGS;
                    end else if (!rx.valid && timed_out) begin
                        state <= P_IDLE;
                    end
                end
                P_ARGS: begin
                    if (rx.valid && is_colon) begin
                        state <= P_OPCODE;
                    end else if (!rx.valid && timed_out) begin
                        state <= P_IDLE;
                    end
                end
                P_EXEC: begin
                    state <= reply_ready ? P_IDLE : P_REPLY;
                end
                P_REPLY: begin
                    if (reply_ready) begin
                        state <= P_IDLE;
                    end
                end
                default: state <= P_IDLE;
            endcase

            if (finish) begin
                state        <= P_EXEC;
                reply_ok     <= pass;
                error_led    <= !pass;
                wr_pending   <= pass && (state == P_ARGS);
                load_pending <= pass && ((state == P_OPCODE) || (cmd_kind == ROTOR));
            end
        end
    end

    // Silence counter and argument capture
    always_ff @(posedge clk) begin
        if (!((state == P_OPCODE) || (state == P_ARGS)) || rx.valid) begin
            idle_cnt <= '0;
        end else begin
            idle_cnt <= idle_cnt + tmo_cnt_t'(1);
        end

        if ((state == P_OPCODE) && rx.valid && is_arg_opcode) begin
            cmd_kind <= new_kind;
            arg_buf  <= '0;
            arg_cnt  <= 2'd0;
            args_ok  <= 1'b1;
        end else if (arg_take) begin
            arg_cnt <= arg_cnt + 2'd1;
            args_ok <= args_ok && arg_ok;
            if (cmd_kind == ROTOR) begin
                arg_buf <= {arg_buf[11:0], digit};
            end else begin
                arg_buf <= {arg_buf[9:0], letter_of(rx.data)};
            end
        end
    end

    assign cmd_active = (state != P_IDLE);
    assign load_pulse = (state == P_EXEC) && load_pending;
    assign cfg_wr     = '{valid: (state == P_EXEC) && wr_pending, kind: cmd_kind, data: arg_buf};
    assign reply_req  = '{valid: (state == P_EXEC) || (state == P_REPLY), ok: reply_ok};

endmodule

// ==== hw/reply_streamer.sv ====
`timescale 1ns/100ps

module reply_streamer #(
    parameter int unsigned startup_delay = enigma_pkg::STARTUP_DELAY_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tx_busy,
    output enigma_pkg::byte_t       tx_byte,
    output logic                    tx_start,
    output logic                    input_open,
    input  enigma_pkg::letter_req_t letter_req,
    output logic                    letter_ready,
    input  enigma_pkg::reply_req_t  reply_req,
    output logic                    reply_ready
);

    import enigma_pkg::*;

    typedef enum logic [2:0] {
        S_DELAY,
        S_BANNER,
        S_IDLE,
        S_SEND,
        S_ACK
    } stream_state_e;

    typedef logic [$clog2(startup_delay + 1) - 1:0] dly_cnt_t;
    typedef logic [$clog2(BANNER_LEN) - 1:0]         pos_t;

    stream_state_e state;
    dly_cnt_t      dly_cnt;
    pos_t          byte_idx;
    pos_t          item_last;
    logic          sel_reply;

    function automatic byte_t banner_byte(input pos_t idx);
        case (idx)
            4'd0:    return "E";
            4'd1:    return "N";
            4'd2:    return "I";
            4'd3:    return "G";
            4'd4:    return "M";
            4'd5:    return "A";
            4'd6:    return " ";
            4'd7:    return "I";
            4'd8:    return " ";
            4'd9:    return "R";
            4'd10:   return "E";
            4'd11:   return "A";
            4'd12:   return "D";
            4'd13:   return "Y";
            4'd14:   return CHAR_CR;
            default: return CHAR_LF;
        endcase
    endfunction

    // "OK" or "ERR", each closed by CR LF
    function automatic byte_t reply_byte(input logic ok, input pos_t idx);
        if (ok) begin
            case (idx)
                4'd0:    return "O";
                4'd1:    return "K";
                4'd2:    return CHAR_CR;
                default: return CHAR_LF;
            endcase
        end
        case (idx)
            4'd0:    return "E";
            4'd1:    return "R";
            4'd2:    return "R";
            4'd3:    return CHAR_CR;
            default: return CHAR_LF;
        endcase
    endfunction

    // Requests hold their payload, so bytes come straight from them
    always_comb begin
        if (state == S_BANNER) begin
            tx_byte   = banner_byte(byte_idx);
            item_last = pos_t'(BANNER_LEN - 1);
        end else if (sel_reply) begin
            tx_byte   = reply_byte(reply_req.ok, byte_idx);
            item_last = reply_req.ok ? pos_t'(3) : pos_t'(4);
        end else begin
            tx_byte   = letter_req.ch;
            item_last = '0;
        end
    end

    // tx_busy rises the cycle after a start, which spaces the bytes
    assign tx_start = ((state == S_BANNER) || (state == S_SEND)) && !tx_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_DELAY;
            dly_cnt   <= '0;
            byte_idx  <= '0;
            sel_reply <= 1'b0;
        end else begin
            case (state)
                S_DELAY: begin
                    if (dly_cnt == dly_cnt_t'(startup_delay - 1)) begin
                        state <= S_BANNER;
                    end else begin
                        dly_cnt <= dly_cnt + dly_cnt_t'(1);
                    end
                end
                S_BANNER, S_SEND: begin
                    if (tx_start) begin
                        if (byte_idx == item_last) begin
                            byte_idx <= '0;
                            state    <= (state == S_BANNER) ? S_IDLE : S_ACK;
                        end else begin
                            byte_idx <= byte_idx + pos_t'(1);
                        end
                    end
                end
                S_IDLE: begin
                    // Replies go ahead of letters
                    if (reply_req.valid) begin
                        sel_reply <= 1'b1;
                        state     <= S_SEND;
                    end else if (letter_req.valid) begin
                        sel_reply <= 1'b0;
                        state     <= S_SEND;
                    end
                end
                S_ACK:   state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    assign input_open   = (state != S_DELAY) && (state != S_BANNER);
    assign letter_ready = (state == S_ACK) && !sel_reply;
    assign reply_ready  = (state == S_ACK) && sel_reply;

endmodule

// ==== hw/enigma_controller.sv ====
`timescale 1ns/100ps

module enigma_controller #(
    parameter int unsigned startup_delay  = enigma_pkg::STARTUP_DELAY_DEFAULT,
    parameter int unsigned timeout_cycles = enigma_pkg::TIMEOUT_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  enigma_pkg::rx_t         rx,
    input  logic                    tx_busy,
    output enigma_pkg::byte_t       tx_byte,
    output logic                    tx_start,
    output enigma_pkg::letter_idx_t pt_index,
    input  enigma_pkg::letter_idx_t ct_index,
    output logic                    step_pulse,
    output logic                    load_pulse,
    output enigma_pkg::cfg_write_t  cfg_wr,
    output logic                    error_led
);

    import enigma_pkg::*;

    letter_req_t letter_req;
    reply_req_t  reply_req;
    logic        letter_ready;
    logic        reply_ready;
    logic        input_open;
    logic        letter_busy;
    logic        cmd_active;

    // ==============================
    // Keystroke path
    // ==============================
    keystroke_sequencer sequencer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx           (rx),
        .input_open   (input_open),
        .cmd_active   (cmd_active),
        .ct_index     (ct_index),
        .pt_index     (pt_index),
        .step_pulse   (step_pulse),
        .letter_req   (letter_req),
        .letter_ready (letter_ready),
        .letter_busy  (letter_busy)
    );

    // ==============================
    // Command path
    // ==============================
    command_parser #(
        .timeout_cycles (timeout_cycles)
    ) parser_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx          (rx),
        .input_open  (input_open),
        .letter_busy (letter_busy),
        .cmd_active  (cmd_active),
        .cfg_wr      (cfg_wr),
        .load_pulse  (load_pulse),
        .reply_req   (reply_req),
        .reply_ready (reply_ready),
        .error_led   (error_led)
    );

    // Banner, replies and letters share the transmitter
    reply_streamer #(
        .startup_delay (startup_delay)
    ) streamer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .tx_busy      (tx_busy),
        .tx_byte      (tx_byte),
        .tx_start     (tx_start),
        .input_open   (input_open),
        .letter_req   (letter_req),
        .letter_ready (letter_ready),
        .reply_req    (reply_req),
        .reply_ready  (reply_ready)
    );

endmodule

// ==== verification/enigma_tb_tasks.svh ====
`ifndef ENIGMA_TB_TASKS_SVH
`define ENIGMA_TB_TASKS_SVH

// ==============================
// Failure reporting
// ==============================
task automatic fail_run(input string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1, "stopped at the first failure");
endtask

task automatic value_error(input string msg);
    fail_run($sformatf("error at %0t ns: %s", $time, msg));
endtask

// ==============================
// Stimulus and capture
// ==============================
// Returns 2 ns after a rising edge, where inputs change
task automatic wait_cycles(input int n);
    repeat (n) begin
        @(posedge clk);
        #2;
    end
endtask

// Idle gap first, as a real receiver spaces its bytes
task automatic send_byte(input byte_t b);
    wait_cycles(3);
    rx = '{valid: 1'b1, data: b};
    wait_cycles(1);
    rx = '0;
endtask

task automatic send_line(input string s);
    for (int i = 0; i < s.len(); i++) begin
        send_byte(byte_t'(s[i]));
    end
endtask

task automatic expect_byte(input byte_t expected);
    int    waited;
    byte_t got;
    waited = 0;
    while (tx_log.size() == 0) begin
        assert (waited < BYTE_WAIT_LIMIT)
            else fail_run("Transmitter stayed silent while a byte was expected");
        wait_cycles(1);
        waited++;
    end
    got = tx_log.pop_front();
    assert (got == expected)
        else value_error($sformatf("transmitter sent %h, expected %h", got, expected));
endtask

task automatic expect_bytes(input string s);
    for (int i = 0; i < s.len(); i++) begin
        expect_byte(byte_t'(s[i]));
    end
endtask

// Digits 1 to 5 become rotor numbers 0 to 4, first digit highest
function automatic cfg_data_t rotor_data(input string s);
    cfg_data_t d;
    d = '0;
    for (int i = 0; i < s.len(); i++) begin
        d = (d << 3) | cfg_data_t'(byte_t'(s[i]) - 8'h31);
    end
    return d;
endfunction

function automatic cfg_data_t letter_data(input string s);
    cfg_data_t d;
    d = '0;
    for (int i = 0; i < s.len(); i++) begin
        d = (d << 5) | cfg_data_t'(byte_t'(s[i]) - CHAR_A);
    end
    return d;
endfunction

// One keystroke, one step, one upper-case output letter
task automatic type_letter(input byte_t ch, input letter_idx_t idx);
    byte_t expected;
    exp_steps++;
    expected = CHAR_A + byte_t'((int'(idx) + exp_steps) % LETTER_COUNT);
    send_byte(ch);
    expect_byte(expected);
    assert (step_cnt == exp_steps)
        else value_error($sformatf("%0d step pulses, expected %0d", step_cnt, exp_steps));
    assert (!error_led) else value_error("error LED still lit after a letter");
endtask

task automatic run_command(input string line, input bit ok, input bit writes,
                           input cfg_kind_e kind, input cfg_data_t data, input bit loads);
    int         loads_before;
    cfg_write_t wr;
    string      reply;
    loads_before = load_cnt;
    if (ok) begin
        reply = "OK\r\n";
    end else begin
        reply = "ERR\r\n";
    end
    send_line(line);
    expect_bytes(reply);
    if (writes) begin
        assert (cfg_log.size() == 1)
            else value_error($sformatf("%0d config writes, expected 1", cfg_log.size()));
        wr = cfg_log.pop_front();
        assert ((wr.kind == kind) && (wr.data == data))
            else value_error($sformatf("config write kind %0d data %h, expected %0d %h",
                                       wr.kind, wr.data, kind, data));
    end else begin
        assert (cfg_log.size() == 0) else value_error("unexpected config write");
    end
    assert (load_cnt == loads_before + int'(loads))
        else value_error($sformatf("%0d load pulses, expected %0d",
                                   load_cnt - loads_before, loads));
    assert (error_led == !ok) else value_error("error LED does not match the reply");
    assert (step_cnt == exp_steps) else value_error("a command stepped the rotors");
endtask

// ==============================
// Directed tests
// ==============================
task automatic banner_check();
    // Both land before the banner has finished
    wait_cycles(10);
    send_byte("Q");
    wait_cycles(80);
    send_byte("w");
    send_byte(CHAR_COLON);
    expect_bytes("ENIGMA I READY\r\n");
    wait_cycles(40);
    assert (tx_log.size() == 0) else value_error("output from input sent before the banner");
    assert (step_cnt == 0) else value_error("rotors stepped before the banner ended");
endtask

task automatic random_letters();
    letter_idx_t idx;
    byte_t       ch;
    repeat (LETTER_TESTS) begin
        idx = letter_idx_t'($urandom % LETTER_COUNT);
        if ($urandom % 2 != 0) begin
            ch = 8'h61 + byte_t'(idx);
        end else begin
            ch = CHAR_A + byte_t'(idx);
        end
        type_letter(ch, idx);
    end
endtask

task automatic rotor_commands();
    run_command(":R312\r", 1'b1, 1'b1, ROTOR, rotor_data("312"), 1'b1);
    run_command(":R113\r", 1'b0, 1'b0, ROTOR, '0, 1'b0);
    run_command(":R6\r", 1'b0, 1'b0, ROTOR, '0, 1'b0);
    // Next letter turns the LED off
    type_letter("k", letter_idx_t'(10));
endtask

task automatic ring_and_ground();
    run_command(":NABC\r", 1'b1, 1'b1, RING, letter_data("ABC"), 1'b0);
    run_command(":PZZA\r", 1'b1, 1'b1, GROUND, letter_data("ZZA"), 1'b0);
    run_command(":N1BC\r", 1'b0, 1'b0, RING, '0, 1'b0);
endtask

task automatic reload_and_unknown();
    run_command(":G", 1'b1, 1'b0, GROUND, '0, 1'b1);
    run_command(":X", 1'b0, 1'b0, GROUND, '0, 1'b0);
endtask

task automatic timeout_and_restart();
    send_byte(CHAR_COLON);
    wait_cycles(PARSER_TIMEOUT + 60);
    assert (tx_log.size() == 0) else value_error("reply sent for a silent command");
    type_letter("E", letter_idx_t'(4));
    run_command(":R1:PABC\r", 1'b1, 1'b1, GROUND, letter_data("ABC"), 1'b0);
endtask

`endif

// ==== verification/enigma_tb.sv ====
`timescale 1ns/100ps

module enigma_tb;

    import enigma_pkg::*;

    // ==============================
    // Run parameters
    // ==============================
    localparam int unsigned STARTUP_CYCLES   = 50;
    localparam int unsigned PARSER_TIMEOUT   = 200;
    localparam int          UART_BUSY_CYCLES = 8;
    localparam int          BYTE_WAIT_LIMIT  = 400;
    localparam int          LETTER_TESTS     = 20;
    localparam logic [31:0] SEED             = 32'h57c32e11;
    // Whole sequence takes under 2000 cycles
    localparam int          CYCLE_LIMIT      = 20000;

    logic        clk;
    logic        rst_n;
    rx_t         rx;
    logic        tx_busy;
    byte_t       tx_byte;
    logic        tx_start;
    letter_idx_t pt_index;
    letter_idx_t ct_index;
    logic        step_pulse;
    logic        load_pulse;
    cfg_write_t  cfg_wr;
    logic        error_led;

    // Model state and logs
    byte_t       tx_log[$];
    cfg_write_t  cfg_log[$];
    letter_idx_t ct_next;
    int          busy_left = 0;
    int          step_cnt  = 0;
    int          load_cnt  = 0;
    int          cycle_cnt = 0;
    int          exp_steps = 0;

    `include "enigma_tb_tasks.svh"

    enigma_controller #(
        .startup_delay  (STARTUP_CYCLES),
        .timeout_cycles (PARSER_TIMEOUT)
    ) enigma_controller_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx),
        .tx_busy    (tx_busy),
        .tx_byte    (tx_byte),
        .tx_start   (tx_start),
        .pt_index   (pt_index),
        .ct_index   (ct_index),
        .step_pulse (step_pulse),
        .load_pulse (load_pulse),
        .cfg_wr     (cfg_wr),
        .error_led  (error_led)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==============================
    // UART, cipher and config models
    // ==============================
    always @(posedge clk) begin
        assert (!(rst_n && tx_start && tx_busy))
            else fail_run("Transmitter start was raised while the UART was still busy");
        // Stand-in cipher shifts by the step count of the previous cycle
        ct_next = letter_idx_t'((int'(pt_index) + step_cnt) % LETTER_COUNT);
        if (rst_n && tx_start) begin
            tx_log.push_back(tx_byte);
            busy_left = UART_BUSY_CYCLES;
        end else if (busy_left != 0) begin
            busy_left--;
        end
        if (rst_n && step_pulse) begin
            step_cnt++;
        end
        if (rst_n && load_pulse) begin
            load_cnt++;
        end
        if (rst_n && cfg_wr.valid) begin
            cfg_log.push_back(cfg_wr);
        end
        #2;
        tx_busy  = (busy_left != 0);
        ct_index = ct_next;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        assert (cycle_cnt < CYCLE_LIMIT)
            else fail_run($sformatf("Run did not finish within %0d cycles", CYCLE_LIMIT));
    end

    initial begin
        void'($urandom(SEED));
        rst_n    = 1'b0;
        rx       = '0;
        tx_busy  = 1'b0;
        ct_index = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        banner_check();
        random_letters();
        rotor_commands();
        ring_and_ground();
        reload_and_unknown();
        timeout_and_restart();

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+verification
hw/enigma_pkg.sv
hw/keystroke_sequencer.sv
hw/command_parser.sv
hw/reply_streamer.sv
hw/enigma_controller.sv
verification/enigma_tb.sv

// ==== Makefile ====
BIN  = obj_dir/Venigma_tb
SRCS = hw/enigma_pkg.sv hw/keystroke_sequencer.sv hw/command_parser.sv \
       hw/reply_streamer.sv hw/enigma_controller.sv \
       verification/enigma_tb.sv verification/enigma_tb_tasks.svh

.PHONY: all run clean

all: run

$(BIN): filelist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module enigma_tb \
		-f filelist.f -o Venigma_tb

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
